// File: Makefile
SRCS := $(shell cat project.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_icache: project.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_icache \
		-f project.f -o Vtb_icache

run: obj_dir/Vtb_icache
	./obj_dir/Vtb_icache | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/icache_pkg.sv
package icache_pkg;

  // index field width, sets per way must fit in it
  localparam int IDX_BITS = 4;

  typedef logic [31:0] word_t;

  // word address, addr[31:2]; the full value doubles as the tag
  typedef logic [29:0] line_addr_t;

  // broadcast to every way while a request is looked up
  typedef struct packed {
    logic                valid;
    logic [IDX_BITS-1:0] index;
    line_addr_t          line;
  } lookup_t;

  // refill entry, write enables travel per way
  typedef struct packed {
    logic [IDX_BITS-1:0] index;
    line_addr_t          line;
    word_t               data;
  } fill_t;

  typedef struct packed {
    logic  hit;
    word_t data;
  } way_res_t;

  // axi read address channel, single beat
  typedef struct packed {
    logic  valid;
    word_t addr;
  } axi_ar_t;

  // axi read data channel, no resp modelled
  typedef struct packed {
    logic  valid;
    word_t data;
  } axi_r_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_AR,
    ST_R
  } ctrl_state_e;

endpackage

// File: design/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 16
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               req_valid_i,
  input  icache_pkg::word_t  req_addr_i,
  output logic               rdata_valid_o,
  output icache_pkg::word_t  rdata_o,
  output icache_pkg::axi_ar_t ar_o,
  input  logic               ar_ready_i,
  input  icache_pkg::axi_r_t r_i,
  output logic               r_ready_o
);

  import icache_pkg::*;

  localparam int WAY_BITS = $clog2(NUM_WAYS);

  lookup_t               lookup;
  fill_t                 fill;
  logic [NUM_WAYS-1:0]   fill_we;
  logic                  refill_done;
  logic                  hit;
  word_t                 hit_data;
  logic [WAY_BITS-1:0]   victim;
  way_res_t              way_res [NUM_WAYS];

  icache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .rdata_valid_o(rdata_valid_o),
    .rdata_o      (rdata_o),
    .ar_o         (ar_o),
    .ar_ready_i   (ar_ready_i),
    .r_i          (r_i),
    .r_ready_o    (r_ready_o),
    .lookup_o     (lookup),
    .fill_o       (fill),
    .fill_we_o    (fill_we),
    .refill_done_o(refill_done),
    .hit_i        (hit),
    .hit_data_i   (hit_data),
    .victim_i     (victim)
  );

  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    icache_way #(.NUM_SETS(NUM_SETS)) u_way (
      .clk      (clk),
      .rst_i    (rst_i),
      .lookup_i (lookup),
      .fill_i   (fill),
      .fill_we_i(fill_we[g]),
      .res_o    (way_res[g])
    );
  end

  way_select #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_way_select (
    .clk          (clk),
    .rst_i        (rst_i),
    .lookup_i     (lookup),
    .res_i        (way_res),
    .refill_done_i(refill_done),
    .hit_o        (hit),
    .hit_data_o   (hit_data),
    .victim_o     (victim)
  );

endmodule

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
  parameter int NUM_WAYS = 4
) (
  input  logic                        clk,
  input  logic                        rst_i,
  // fetch side
  input  logic                        req_valid_i,
  input  icache_pkg::word_t           req_addr_i,
  output logic                        rdata_valid_o,
  output icache_pkg::word_t           rdata_o,
  // axi read master
  output icache_pkg::axi_ar_t         ar_o,
  input  logic                        ar_ready_i,
  input  icache_pkg::axi_r_t          r_i,
  output logic                        r_ready_o,
  // way array
  output icache_pkg::lookup_t         lookup_o,
  output icache_pkg::fill_t           fill_o,
  output logic [NUM_WAYS-1:0]         fill_we_o,
  output logic                        refill_done_o,
  input  logic                        hit_i,
  input  icache_pkg::word_t           hit_data_i,
  input  logic [$clog2(NUM_WAYS)-1:0] victim_i
);

  import icache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  line_addr_t  req_line_q;  // captured word address
  logic        accept;
  logic        r_beat;

  // the fetcher still holds the old request during the response pulse
  assign accept = (state_q == ST_IDLE) && req_valid_i && !rdata_valid_o;
  assign r_beat = r_i.valid && r_ready_o;

  // memory side
  always_comb begin
    ar_o.valid = (state_q == ST_AR);
    ar_o.addr  = {req_line_q, 2'b00};
  end

  assign r_ready_o = (state_q == ST_R);

  // lookup and fill share the captured address
  always_comb begin
    lookup_o.valid = (state_q == ST_LOOKUP);
    lookup_o.index = req_line_q[IDX_BITS-1:0];
    lookup_o.line  = req_line_q;
    fill_o.index   = req_line_q[IDX_BITS-1:0];
    fill_o.line    = req_line_q;
    fill_o.data    = r_i.data;
  end

  always_comb begin
    fill_we_o = '0;
    if (r_beat) begin
      fill_we_o[victim_i] = 1'b1;  // one-hot into the victim way
    end
  end

  assign refill_done_o = r_beat;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        state_d = hit_i ? ST_IDLE : ST_AR;
      end
      ST_AR: begin
        if (ar_ready_i) begin
          state_d = ST_R;
        end
      end
      ST_R: begin
        if (r_i.valid) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q       <= ST_IDLE;
      rdata_valid_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      rdata_valid_o <= ((state_q == ST_LOOKUP) && hit_i) || r_beat;
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_line_q <= req_addr_i[31:2];
    end
    if ((state_q == ST_LOOKUP) && hit_i) begin
      rdata_o <= hit_data_i;
    end else if (r_beat) begin
      rdata_o <= r_i.data;  // refill word goes straight back
    end
  end

  // address and valid held until the slave takes them
  ar_stable_a: assert property (
    @(posedge clk) disable iff (rst_i)
    ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o.addr)
  ) else $error("ar address changed before handshake");

endmodule

// File: icache/icache_way.sv
`timescale 1ns/1ps

module icache_way #(
  parameter int NUM_SETS = 16
) (
  input  logic                clk,
  input  logic                rst_i,
  input  icache_pkg::lookup_t lookup_i,
  input  icache_pkg::fill_t   fill_i,
  input  logic                fill_we_i,
  output icache_pkg::way_res_t res_o
);

  import icache_pkg::*;

  localparam int SET_BITS = $clog2(NUM_SETS);

  logic [NUM_SETS-1:0] valid_q;
  line_addr_t          tag_q  [NUM_SETS];
  word_t               data_q [NUM_SETS];

  logic [SET_BITS-1:0] rd_idx;
  logic [SET_BITS-1:0] wr_idx;

  // only the low index bits select a set
  assign rd_idx = lookup_i.index[SET_BITS-1:0];
  assign wr_idx = fill_i.index[SET_BITS-1:0];

  // tag compare
  always_comb begin
    res_o.hit  = lookup_i.valid && valid_q[rd_idx] && (tag_q[rd_idx] == lookup_i.line);
    res_o.data = data_q[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (fill_we_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      tag_q[wr_idx]  <= fill_i.line;
      data_q[wr_idx] <= fill_i.data;
    end
  end

endmodule

// File: icache/way_select.sv
`timescale 1ns/1ps

module way_select #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 16
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  icache_pkg::lookup_t         lookup_i,
  input  icache_pkg::way_res_t        res_i [NUM_WAYS],
  input  logic                        refill_done_i,
  output logic                        hit_o,
  output icache_pkg::word_t           hit_data_o,
  output logic [$clog2(NUM_WAYS)-1:0] victim_o
);

  import icache_pkg::*;

  localparam int WAY_BITS = $clog2(NUM_WAYS);
  localparam int SET_BITS = $clog2(NUM_SETS);

  logic [NUM_SETS-1:0][WAY_BITS-1:0] ptr_q;  // round-robin victim per set
  logic [NUM_WAYS-1:0]               hits;
  logic [SET_BITS-1:0]               set_idx;
  word_t                             data_mux;

  assign set_idx = lookup_i.index[SET_BITS-1:0];

  // and-or mux relies on a single hitting way
  always_comb begin
    data_mux = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hits[w] = res_i[w].hit;
      if (res_i[w].hit) begin
        data_mux = data_mux | res_i[w].data;
      end
    end
  end

  assign hit_o      = |hits;
  assign hit_data_o = data_mux;
  assign victim_o   = ptr_q[set_idx];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (refill_done_i) begin
      ptr_q[set_idx] <= ptr_q[set_idx] + 1'b1;  // power-of-two ways wrap to 0
    end
  end

  // a line is only ever filled into one way
  one_hit_a: assert property (
    @(posedge clk) disable iff (rst_i)
    lookup_i.valid |-> $onehot0(hits)
  ) else $error("more than one way hit");

endmodule

// File: project.f
common/icache_pkg.sv
icache/icache_way.sv
icache/way_select.sv
icache/icache_ctrl.sv
design/icache_top.sv
tests/tb_icache.sv

// File: tests/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

  import icache_pkg::*;

  localparam int NUM_WAYS     = 4;
  localparam int NUM_SETS     = 16;
  localparam int NUM_REQ      = 400;
  localparam int DIRECTED_REQ = 7;
  localparam int POOL_SIZE    = 24;
  localparam int RESET_CYCLES = 10;
  localparam int CYCLE_LIMIT  = (NUM_REQ + DIRECTED_REQ) * 14 + RESET_CYCLES;

  logic    clk = 1'b0;
  logic    rst_i;
  logic    req_valid_i;
  word_t   req_addr_i;
  logic    rdata_valid_o;
  word_t   rdata_o;
  axi_ar_t ar_o;
  logic    ar_ready_i;
  axi_r_t  r_i;
  logic    r_ready_o;

  // reference cache, one entry per set and way
  logic       m_valid [NUM_SETS][NUM_WAYS];
  line_addr_t m_tag   [NUM_SETS][NUM_WAYS];
  word_t      m_data  [NUM_SETS][NUM_WAYS];
  int         m_ptr   [NUM_SETS];

  logic [31:0] rand_state = 32'hd11fcbb0;
  word_t       pool [POOL_SIZE];
  int          error_count = 0;
  int          cycle_count = 0;
  int          hit_count = 0;
  int          miss_count = 0;

  // axi responder and protocol monitor
  logic  ar_valid_prev = 1'b0;
  word_t ar_addr_prev = '0;
  logic  r_ready_prev = 1'b0;
  bit    ar_pending = 1'b0;
  int    ar_delay = 0;
  bit    r_pending = 1'b0;
  int    r_delay = 0;
  bit    r_wait = 1'b0;    // between ar handshake and r beat
  word_t r_addr = '0;
  int    ar_count = 0;
  word_t ar_last_addr = '0;

  icache_top #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) dut (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .rdata_valid_o(rdata_valid_o),
    .rdata_o      (rdata_o),
    .ar_o         (ar_o),
    .ar_ready_i   (ar_ready_i),
    .r_i          (r_i),
    .r_ready_o    (r_ready_o)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: run stuck after %0d cycles, errors %0d", cycle_count, error_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic word_t mem_word(input word_t addr);
    return addr ^ 32'h5a5a_0f0f;
  endfunction

  // returns 1 on a predicted hit, fills the pointed way on a miss
  function automatic bit model_lookup(input word_t addr, output word_t data);
    line_addr_t line;
    int         set;
    bit         found;
    line  = addr[31:2];
    set   = int'(line % NUM_SETS);
    found = 1'b0;
    data  = mem_word({line, 2'b00});
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && m_valid[set][w] && m_tag[set][w] == line) begin
        found = 1'b1;
        data  = m_data[set][w];
      end
    end
    if (!found) begin
      m_valid[set][m_ptr[set]] = 1'b1;
      m_tag[set][m_ptr[set]]   = line;
      m_data[set][m_ptr[set]]  = data;
      m_ptr[set]               = (m_ptr[set] + 1) % NUM_WAYS;
    end
    return found;
  endfunction

  task automatic log_mismatch(input string name, input word_t got, input word_t exp);
    $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    error_count++;
  endtask

  task automatic log_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    error_count++;
  endtask

  // one clock, then responder and protocol checks 1 ns after the edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
    if (ar_valid_prev && ar_ready_i) begin
      ar_count++;
      ar_last_addr = ar_addr_prev;
      ar_pending   = 1'b0;
      ar_ready_i   = 1'b0;
      r_pending    = 1'b1;
      r_wait       = 1'b1;
      r_addr       = ar_addr_prev;
      r_delay      = int'((next_rand() >> 16) % 4);
    end else if (ar_valid_prev) begin
      if (!ar_o.valid) begin
        log_error("ar_o.valid dropped before the address handshake");
      end else if (ar_o.addr != ar_addr_prev) begin
        log_mismatch("ar_o.addr", ar_o.addr, ar_addr_prev);
      end
    end
    if (r_i.valid && r_ready_prev) begin
      r_i       = '0;
      r_pending = 1'b0;
      r_wait    = 1'b0;
    end
    if (r_wait && !r_ready_o) begin
      log_error("r_ready_o low while waiting for the read data beat");
    end
    if (ar_o.valid && !ar_pending) begin
      ar_pending = 1'b1;
      ar_delay   = int'((next_rand() >> 16) % 4);  // 0 to 3 cycles
    end
    if (ar_pending && !ar_ready_i) begin
      if (ar_delay == 0) ar_ready_i = 1'b1;
      else ar_delay--;
    end
    if (r_pending && !r_i.valid) begin
      if (r_delay == 0) begin
        r_i.valid = 1'b1;
        r_i.data  = mem_word(r_addr);
      end else begin
        r_delay--;
      end
    end
    ar_valid_prev = ar_o.valid;
    ar_addr_prev  = ar_o.addr;
    r_ready_prev  = r_ready_o;
  endtask

  task automatic run_request(input word_t addr, output bit got_ar);
    bit    exp_hit;
    word_t exp_data;
    int    edges;
    int    ar_start;
    exp_hit     = model_lookup(addr, exp_data);
    ar_start    = ar_count;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    step_cycle();  // capture edge
    edges = 1;
    while (!rdata_valid_o) begin
      step_cycle();
      edges++;
    end
    req_valid_i = 1'b0;
    got_ar = (ar_count != ar_start);
    if (rdata_o != exp_data) log_mismatch("rdata_o", rdata_o, exp_data);
    if (exp_hit) begin
      hit_count++;
      if (got_ar) log_error($sformatf("AR issued for predicted hit at %h", addr));
      if (edges != 2) log_error($sformatf("hit answered after %0d edges, not 2", edges));
    end else begin
      miss_count++;
      if (ar_count - ar_start != 1) begin
        log_error($sformatf("miss at %h saw %0d AR transfers", addr, ar_count - ar_start));
      end else if (ar_last_addr != {addr[31:2], 2'b00}) begin
        log_mismatch("ar_o.addr", ar_last_addr, {addr[31:2], 2'b00});
      end
    end
    step_cycle();
    if (rdata_valid_o) log_error("rdata_valid_o high for more than one cycle");
  endtask

  initial begin
    word_t addr;
    bit    got_ar;
    int    idx;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    ar_ready_i  = 1'b0;
    r_i         = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_ptr[s] = 0;
      for (int w = 0; w < NUM_WAYS; w++) m_valid[s][w] = 1'b0;
    end
    // 6 tags in each of sets 1, 5, 9 and 13
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = (next_rand() & 32'hfff0_0000) | (word_t'(i / 4) << 6)
              | (word_t'(1 + (i % 4) * 4) << 2);
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_i = 1'b0;
    for (int k = 0; k < 2; k++) begin
      if (rdata_valid_o || ar_o.valid || r_ready_o) begin
        log_error("rdata_valid_o, ar_o.valid or r_ready_o high after reset");
      end
      step_cycle();
    end

    // five tags into set 3, then the first one must be gone
    for (int k = 1; k <= 5; k++) begin
      run_request((word_t'(k) << 12) | 32'h0000_000c, got_ar);
    end
    run_request(32'h0000_100c, got_ar);
    if (!got_ar) log_error("first tag of set 3 still cached after five fills");
    run_request(32'h0000_500c, got_ar);
    if (got_ar) log_error("recent tag of set 3 was refilled again");

    for (int n = 0; n < NUM_REQ; n++) begin
      idx  = int'((next_rand() >> 8) % POOL_SIZE);
      addr = pool[idx] | (next_rand() & 32'h3);  // byte offset is ignored
      run_request(addr, got_ar);
      if (((next_rand() >> 20) & 32'h1) != 0) step_cycle();
    end

    $display("requests %0d, hits %0d, misses %0d, errors %0d",
             hit_count + miss_count, hit_count, miss_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
